//--- hw/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // Slave and master ports share one address width
  localparam int unsigned AddrWidth = 32;
  // W and R payload width
  localparam int unsigned DataWidth = 32;
  // Transaction id width, same on both ports
  localparam int unsigned IdWidth = 4;
  // Burst length field, beats minus one
  localparam int unsigned LenWidth = 8;

  // Basic field types of the reduced AXI4 subset
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [LenWidth-1:0]  len_t;

  // Response codes on B and R
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

//--- hw/remap_pkg.sv
`default_nettype none

package remap_pkg;

  // Number of remap windows in the register block
  localparam int unsigned NumWindows = 4;
  // Bits needed to address one window
  localparam int unsigned WinIdxWidth = 2;

  // Window index on the configuration port
  typedef logic [WinIdxWidth-1:0] win_idx_t;

  // Field of a window that a configuration write updates
  // SEL_ENABLE only looks at bit 0 of the write data
  typedef enum logic [1:0] {
    SEL_BASE   = 2'b00,
    SEL_MASK   = 2'b01,
    SEL_TARGET = 2'b10,
    SEL_ENABLE = 2'b11
  } cfg_sel_e;

endpackage

`default_nettype wire

//--- hw/remap_cfg_regs.sv
`default_nettype none

module remap_cfg_regs (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // Configuration write port
  input  logic                                            cfg_valid_i,
  output logic                                            cfg_ready_o,
  input  remap_pkg::win_idx_t                             cfg_win_i,
  input  remap_pkg::cfg_sel_e                             cfg_sel_i,
  input  axi_pkg::addr_t                                  cfg_data_i,
  // Address handshakes waiting on the slave port
  input  logic                                            aw_pending_i,
  input  logic                                            ar_pending_i,
  // Window contents toward both lookups
  output axi_pkg::addr_t [remap_pkg::NumWindows-1:0]      win_base_o,
  output axi_pkg::addr_t [remap_pkg::NumWindows-1:0]      win_mask_o,
  output axi_pkg::addr_t [remap_pkg::NumWindows-1:0]      win_target_o,
  output logic           [remap_pkg::NumWindows-1:0]      win_en_o
);

  // Window register file
  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] base_q;
  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] mask_q;
  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] target_q;
  logic           [remap_pkg::NumWindows-1:0] en_q;

  // Accepted configuration write
  logic cfg_fire;

  // Hold off writes while an AW or AR address is offered but not taken
  // The master side must see a stable address until the handshake ends
  assign cfg_ready_o = ~(aw_pending_i | ar_pending_i);

  assign cfg_fire = cfg_valid_i & cfg_ready_o;

  // Selected field of the selected window updates on the handshake edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // All windows disabled and cleared
      base_q   <= '0;
      mask_q   <= '0;
      target_q <= '0;
      en_q     <= '0;
    end else if (cfg_fire) begin
      unique case (cfg_sel_i)
        remap_pkg::SEL_BASE: begin
          base_q[cfg_win_i] <= cfg_data_i;
        end
        remap_pkg::SEL_MASK: begin
          mask_q[cfg_win_i] <= cfg_data_i;
        end
        remap_pkg::SEL_TARGET: begin
          target_q[cfg_win_i] <= cfg_data_i;
        end
        remap_pkg::SEL_ENABLE: begin
          // Only bit 0 carries the enable
          en_q[cfg_win_i] <= cfg_data_i[0];
        end
      endcase
    end
  end

  // Registers feed the lookups directly
  assign win_base_o   = base_q;
  assign win_mask_o   = mask_q;
  assign win_target_o = target_q;
  assign win_en_o     = en_q;

endmodule

`default_nettype wire

//--- hw/remap_lookup.sv
`default_nettype none

module remap_lookup (
  // Untranslated address from the slave port
  input  axi_pkg::addr_t                             addr_i,
  // Window contents from the register block
  input  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] win_base_i,
  input  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] win_mask_i,
  input  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] win_target_i,
  input  logic           [remap_pkg::NumWindows-1:0] win_en_i,
  // Address for the master port
  output axi_pkg::addr_t                             addr_o
);

  // One hit bit per window
  logic [remap_pkg::NumWindows-1:0] hit;
  // Set once a lower window has already claimed the address
  logic                             found;

  // Compare only the bits the mask selects
  for (genvar k = 0; k < remap_pkg::NumWindows; k++) begin : g_match
    assign hit[k] = win_en_i[k] &
                    ((addr_i & win_mask_i[k]) == (win_base_i[k] & win_mask_i[k]));
  end

  // Scan upward so the lowest matching window wins
  always_comb begin
    addr_o = addr_i;
    found  = 1'b0;
    for (int k = 0; k < remap_pkg::NumWindows; k++) begin
      if (hit[k] && !found) begin
        // Masked bits from the target, rest kept from the original
        addr_o = (win_target_i[k] & win_mask_i[k]) | (addr_i & ~win_mask_i[k]);
        found  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/axi_modify_address.sv
`default_nettype none

module axi_modify_address (
  // Slave port, AW without its address
  input  logic                slv_aw_valid_i,
  output logic                slv_aw_ready_o,
  input  axi_pkg::id_t        slv_aw_id_i,
  input  axi_pkg::len_t       slv_aw_len_i,
  // Slave port, W
  input  logic                slv_w_valid_i,
  output logic                slv_w_ready_o,
  input  axi_pkg::data_t      slv_w_data_i,
  input  logic                slv_w_last_i,
  // Slave port, B
  output logic                slv_b_valid_o,
  input  logic                slv_b_ready_i,
  output axi_pkg::id_t        slv_b_id_o,
  output axi_pkg::resp_e      slv_b_resp_o,
  // Slave port, AR without its address
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  input  axi_pkg::id_t        slv_ar_id_i,
  input  axi_pkg::len_t       slv_ar_len_i,
  // Slave port, R
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  output axi_pkg::id_t        slv_r_id_o,
  output axi_pkg::data_t      slv_r_data_o,
  output axi_pkg::resp_e      slv_r_resp_o,
  output logic                slv_r_last_o,
  // Translated addresses, stable while their handshake is pending
  input  axi_pkg::addr_t      mst_aw_addr_i,
  input  axi_pkg::addr_t      mst_ar_addr_i,
  // Master port, AW
  output logic                mst_aw_valid_o,
  input  logic                mst_aw_ready_i,
  output axi_pkg::id_t        mst_aw_id_o,
  output axi_pkg::addr_t      mst_aw_addr_o,
  output axi_pkg::len_t       mst_aw_len_o,
  // Master port, W
  output logic                mst_w_valid_o,
  input  logic                mst_w_ready_i,
  output axi_pkg::data_t      mst_w_data_o,
  output logic                mst_w_last_o,
  // Master port, B
  input  logic                mst_b_valid_i,
  output logic                mst_b_ready_o,
  input  axi_pkg::id_t        mst_b_id_i,
  input  axi_pkg::resp_e      mst_b_resp_i,
  // Master port, AR
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  output axi_pkg::id_t        mst_ar_id_o,
  output axi_pkg::addr_t      mst_ar_addr_o,
  output axi_pkg::len_t       mst_ar_len_o,
  // Master port, R
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o,
  input  axi_pkg::id_t        mst_r_id_i,
  input  axi_pkg::data_t      mst_r_data_i,
  input  axi_pkg::resp_e      mst_r_resp_i,
  input  logic                mst_r_last_i
);

  // AW keeps id and len, takes the new address
  assign mst_aw_valid_o = slv_aw_valid_i;
  assign mst_aw_id_o    = slv_aw_id_i;
  assign mst_aw_addr_o  = mst_aw_addr_i;
  assign mst_aw_len_o   = slv_aw_len_i;
  assign slv_aw_ready_o = mst_aw_ready_i;

  // Write data untouched
  assign mst_w_valid_o = slv_w_valid_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_last_o  = slv_w_last_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // Write response back to the slave side
  assign slv_b_valid_o = mst_b_valid_i;
  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign mst_b_ready_o = slv_b_ready_i;

  // AR same as AW
  assign mst_ar_valid_o = slv_ar_valid_i;
  assign mst_ar_id_o    = slv_ar_id_i;
  assign mst_ar_addr_o  = mst_ar_addr_i;
  assign mst_ar_len_o   = slv_ar_len_i;
  assign slv_ar_ready_o = mst_ar_ready_i;

  // Read data back to the slave side
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_id_o    = mst_r_id_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

endmodule

`default_nettype wire

//--- hw/axi_remap_top.sv
`default_nettype none

module axi_remap_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Slave port AW
  input  logic                s_aw_valid_i,
  output logic                s_aw_ready_o,
  input  axi_pkg::id_t        s_aw_id_i,
  input  axi_pkg::addr_t      s_aw_addr_i,
  input  axi_pkg::len_t       s_aw_len_i,
  // Slave port W
  input  logic                s_w_valid_i,
  output logic                s_w_ready_o,
  input  axi_pkg::data_t      s_w_data_i,
  input  logic                s_w_last_i,
  // Slave port B
  output logic                s_b_valid_o,
  input  logic                s_b_ready_i,
  output axi_pkg::id_t        s_b_id_o,
  output axi_pkg::resp_e      s_b_resp_o,
  // Slave port AR
  input  logic                s_ar_valid_i,
  output logic                s_ar_ready_o,
  input  axi_pkg::id_t        s_ar_id_i,
  input  axi_pkg::addr_t      s_ar_addr_i,
  input  axi_pkg::len_t       s_ar_len_i,
  // Slave port R
  output logic                s_r_valid_o,
  input  logic                s_r_ready_i,
  output axi_pkg::id_t        s_r_id_o,
  output axi_pkg::data_t      s_r_data_o,
  output axi_pkg::resp_e      s_r_resp_o,
  output logic                s_r_last_o,
  // Master port AW
  output logic                m_aw_valid_o,
  input  logic                m_aw_ready_i,
  output axi_pkg::id_t        m_aw_id_o,
  output axi_pkg::addr_t      m_aw_addr_o,
  output axi_pkg::len_t       m_aw_len_o,
  // Master port W
  output logic                m_w_valid_o,
  input  logic                m_w_ready_i,
  output axi_pkg::data_t      m_w_data_o,
  output logic                m_w_last_o,
  // Master port B
  input  logic                m_b_valid_i,
  output logic                m_b_ready_o,
  input  axi_pkg::id_t        m_b_id_i,
  input  axi_pkg::resp_e      m_b_resp_i,
  // Master port AR
  output logic                m_ar_valid_o,
  input  logic                m_ar_ready_i,
  output axi_pkg::id_t        m_ar_id_o,
  output axi_pkg::addr_t      m_ar_addr_o,
  output axi_pkg::len_t       m_ar_len_o,
  // Master port R
  input  logic                m_r_valid_i,
  output logic                m_r_ready_o,
  input  axi_pkg::id_t        m_r_id_i,
  input  axi_pkg::data_t      m_r_data_i,
  input  axi_pkg::resp_e      m_r_resp_i,
  input  logic                m_r_last_i,
  // Window configuration
  input  logic                cfg_valid_i,
  output logic                cfg_ready_o,
  input  remap_pkg::win_idx_t cfg_win_i,
  input  remap_pkg::cfg_sel_e cfg_sel_i,
  input  axi_pkg::addr_t      cfg_data_i
);

  // Window contents shared by both lookups
  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] win_base;
  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] win_mask;
  axi_pkg::addr_t [remap_pkg::NumWindows-1:0] win_target;
  logic           [remap_pkg::NumWindows-1:0] win_en;

  // Translated addresses
  axi_pkg::addr_t aw_addr_xlat;
  axi_pkg::addr_t ar_addr_xlat;

  // Address offered on the slave side but not yet taken
  logic aw_pending;
  logic ar_pending;

  // Ready mirrors the master side, so this uses the downstream ready
  assign aw_pending = s_aw_valid_i & ~m_aw_ready_i;
  assign ar_pending = s_ar_valid_i & ~m_ar_ready_i;

  remap_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_ready_o  (cfg_ready_o),
    .cfg_win_i    (cfg_win_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_data_i   (cfg_data_i),
    .aw_pending_i (aw_pending),
    .ar_pending_i (ar_pending),
    .win_base_o   (win_base),
    .win_mask_o   (win_mask),
    .win_target_o (win_target),
    .win_en_o     (win_en)
  );

  // Write address translation
  remap_lookup u_aw_lookup (
    .addr_i       (s_aw_addr_i),
    .win_base_i   (win_base),
    .win_mask_i   (win_mask),
    .win_target_i (win_target),
    .win_en_i     (win_en),
    .addr_o       (aw_addr_xlat)
  );

  // Read address translation
  remap_lookup u_ar_lookup (
    .addr_i       (s_ar_addr_i),
    .win_base_i   (win_base),
    .win_mask_i   (win_mask),
    .win_target_i (win_target),
    .win_en_i     (win_en),
    .addr_o       (ar_addr_xlat)
  );

  axi_modify_address u_modify (
    .slv_aw_valid_i (s_aw_valid_i),
    .slv_aw_ready_o (s_aw_ready_o),
    .slv_aw_id_i    (s_aw_id_i),
    .slv_aw_len_i   (s_aw_len_i),
    .slv_w_valid_i  (s_w_valid_i),
    .slv_w_ready_o  (s_w_ready_o),
    .slv_w_data_i   (s_w_data_i),
    .slv_w_last_i   (s_w_last_i),
    .slv_b_valid_o  (s_b_valid_o),
    .slv_b_ready_i  (s_b_ready_i),
    .slv_b_id_o     (s_b_id_o),
    .slv_b_resp_o   (s_b_resp_o),
    .slv_ar_valid_i (s_ar_valid_i),
    .slv_ar_ready_o (s_ar_ready_o),
    .slv_ar_id_i    (s_ar_id_i),
    .slv_ar_len_i   (s_ar_len_i),
    .slv_r_valid_o  (s_r_valid_o),
    .slv_r_ready_i  (s_r_ready_i),
    .slv_r_id_o     (s_r_id_o),
    .slv_r_data_o   (s_r_data_o),
    .slv_r_resp_o   (s_r_resp_o),
    .slv_r_last_o   (s_r_last_o),
    .mst_aw_addr_i  (aw_addr_xlat),
    .mst_ar_addr_i  (ar_addr_xlat),
    .mst_aw_valid_o (m_aw_valid_o),
    .mst_aw_ready_i (m_aw_ready_i),
    .mst_aw_id_o    (m_aw_id_o),
    .mst_aw_addr_o  (m_aw_addr_o),
    .mst_aw_len_o   (m_aw_len_o),
    .mst_w_valid_o  (m_w_valid_o),
    .mst_w_ready_i  (m_w_ready_i),
    .mst_w_data_o   (m_w_data_o),
    .mst_w_last_o   (m_w_last_o),
    .mst_b_valid_i  (m_b_valid_i),
    .mst_b_ready_o  (m_b_ready_o),
    .mst_b_id_i     (m_b_id_i),
    .mst_b_resp_i   (m_b_resp_i),
    .mst_ar_valid_o (m_ar_valid_o),
    .mst_ar_ready_i (m_ar_ready_i),
    .mst_ar_id_o    (m_ar_id_o),
    .mst_ar_addr_o  (m_ar_addr_o),
    .mst_ar_len_o   (m_ar_len_o),
    .mst_r_valid_i  (m_r_valid_i),
    .mst_r_ready_o  (m_r_ready_o),
    .mst_r_id_i     (m_r_id_i),
    .mst_r_data_i   (m_r_data_i),
    .mst_r_resp_i   (m_r_resp_i),
    .mst_r_last_i   (m_r_last_i)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_axi_remap.sv
`default_nettype none

module tb_axi_remap;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Seed           = 69153;
  localparam int unsigned ResetCycles    = 10;
  // Random traffic length of each phase
  localparam int unsigned IdleCycles     = 150;
  localparam int unsigned MappedCycles   = 300;
  localparam int unsigned DisabledCycles = 150;
  // Cycles an address is held back by the master side
  localparam int unsigned HoldCycles     = 6;
  // Sixteen programming writes, one disable, one per hold test
  localparam int unsigned CfgWrites      = 19;
  localparam int unsigned StimCycles     = ResetCycles + IdleCycles + MappedCycles
                                           + DisabledCycles + 2 * CfgWrites
                                           + 2 * (HoldCycles + 3) + 4 * 2;
  localparam int unsigned TimeoutCycles  = 4 * StimCycles;

  // Window 1 sits inside window 0, window 2 inside window 3
  localparam axi_pkg::addr_t BaseCfg [remap_pkg::NumWindows] =
    '{32'h1000_0000, 32'h1200_0000, 32'h4000_0000, 32'h4000_0000};
  localparam axi_pkg::addr_t MaskCfg [remap_pkg::NumWindows] =
    '{32'hF000_0000, 32'hFF00_0000, 32'hFFFF_0000, 32'hFF00_0000};
  localparam axi_pkg::addr_t TargetCfg [remap_pkg::NumWindows] =
    '{32'h8000_0000, 32'h9000_0000, 32'hA5A5_0000, 32'hC000_0000};

  logic clk_i;
  logic rst_n_i;
  // Handshake and last bits of both ports
  logic s_aw_valid_i, s_aw_ready_o, s_w_valid_i, s_w_ready_o, s_w_last_i;
  logic s_b_valid_o, s_b_ready_i, s_ar_valid_i, s_ar_ready_o;
  logic s_r_valid_o, s_r_ready_i, s_r_last_o;
  logic m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_ready_i, m_w_last_o;
  logic m_b_valid_i, m_b_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic m_r_valid_i, m_r_ready_o, m_r_last_i;
  logic cfg_valid_i, cfg_ready_o;
  // Payload fields
  axi_pkg::id_t        s_aw_id_i, s_b_id_o, s_ar_id_i, s_r_id_o;
  axi_pkg::id_t        m_aw_id_o, m_b_id_i, m_ar_id_o, m_r_id_i;
  axi_pkg::addr_t      s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o, cfg_data_i;
  axi_pkg::len_t       s_aw_len_i, s_ar_len_i, m_aw_len_o, m_ar_len_o;
  axi_pkg::data_t      s_w_data_i, s_r_data_o, m_w_data_o, m_r_data_i;
  axi_pkg::resp_e      s_b_resp_o, s_r_resp_o, m_b_resp_i, m_r_resp_i;
  remap_pkg::win_idx_t cfg_win_i;
  remap_pkg::cfg_sel_e cfg_sel_i;

  // Shadow of the window registers, follows observed configuration handshakes
  axi_pkg::addr_t sh_base   [remap_pkg::NumWindows];
  axi_pkg::addr_t sh_mask   [remap_pkg::NumWindows];
  axi_pkg::addr_t sh_target [remap_pkg::NumWindows];
  logic           sh_en     [remap_pkg::NumWindows];

  int unsigned cycle_cnt = 0;

  tb_clk_gen #(.PeriodNs(40), .ResetCycles(ResetCycles)) u_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  axi_remap_top DUT (.*);

  // Lowest enabled window whose masked bits agree with the address
  function automatic axi_pkg::addr_t remap_ref(input axi_pkg::addr_t addr);
    for (int k = 0; k < remap_pkg::NumWindows; k++) begin
      if (sh_en[k] && (((addr ^ sh_base[k]) & sh_mask[k]) == '0)) begin
        return (addr & ~sh_mask[k]) | (sh_target[k] & sh_mask[k]);
      end
    end
    return addr;
  endfunction

  // Mix of window hits, overlaps and misses
  function automatic axi_pkg::addr_t rand_addr();
    axi_pkg::addr_t a;
    a = $urandom;
    case ($urandom_range(0, 4))
      0: a = {8'h12, a[23:0]};
      1: a = {4'h1, a[27:0]};
      2: a = {16'h4000, a[15:0]};
      3: a = {8'h40, a[23:0]};
      default: a = a;
    endcase
    return a;
  endfunction

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic check_addr(input axi_pkg::addr_t got, exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_data(input axi_pkg::data_t got, exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_id(input axi_pkg::id_t got, exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_len(input axi_pkg::len_t got, exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_resp(input axi_pkg::resp_e got, exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  // Master requests and slave responses against their sources
  task automatic check_outputs();
    logic cfg_ready_exp;
    cfg_ready_exp = !((s_aw_valid_i && !m_aw_ready_i) || (s_ar_valid_i && !m_ar_ready_i));
    check_bit(m_aw_valid_o, s_aw_valid_i, "m_aw_valid");
    check_id(m_aw_id_o, s_aw_id_i, "m_aw_id");
    check_addr(m_aw_addr_o, remap_ref(s_aw_addr_i), "m_aw_addr");
    check_len(m_aw_len_o, s_aw_len_i, "m_aw_len");
    check_bit(s_aw_ready_o, m_aw_ready_i, "s_aw_ready");
    check_bit(m_ar_valid_o, s_ar_valid_i, "m_ar_valid");
    check_id(m_ar_id_o, s_ar_id_i, "m_ar_id");
    check_addr(m_ar_addr_o, remap_ref(s_ar_addr_i), "m_ar_addr");
    check_len(m_ar_len_o, s_ar_len_i, "m_ar_len");
    check_bit(s_ar_ready_o, m_ar_ready_i, "s_ar_ready");
    check_bit(m_w_valid_o, s_w_valid_i, "m_w_valid");
    check_data(m_w_data_o, s_w_data_i, "m_w_data");
    check_bit(m_w_last_o, s_w_last_i, "m_w_last");
    check_bit(s_w_ready_o, m_w_ready_i, "s_w_ready");
    check_bit(s_b_valid_o, m_b_valid_i, "s_b_valid");
    check_id(s_b_id_o, m_b_id_i, "s_b_id");
    check_resp(s_b_resp_o, m_b_resp_i, "s_b_resp");
    check_bit(m_b_ready_o, s_b_ready_i, "m_b_ready");
    check_bit(s_r_valid_o, m_r_valid_i, "s_r_valid");
    check_id(s_r_id_o, m_r_id_i, "s_r_id");
    check_data(s_r_data_o, m_r_data_i, "s_r_data");
    check_resp(s_r_resp_o, m_r_resp_i, "s_r_resp");
    check_bit(s_r_last_o, m_r_last_i, "s_r_last");
    check_bit(m_r_ready_o, s_r_ready_i, "m_r_ready");
    check_bit(cfg_ready_o, cfg_ready_exp, "cfg_ready_o");
  endtask

  task automatic init_inputs();
    s_aw_valid_i = 1'b0;
    s_aw_id_i    = '0;
    s_aw_addr_i  = '0;
    s_aw_len_i   = '0;
    s_w_valid_i  = 1'b0;
    s_w_data_i   = '0;
    s_w_last_i   = 1'b0;
    s_b_ready_i  = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_r_ready_i  = 1'b0;
    m_aw_ready_i = 1'b0;
    m_w_ready_i  = 1'b0;
    m_b_valid_i  = 1'b0;
    m_b_id_i     = '0;
    m_b_resp_i   = axi_pkg::OKAY;
    m_ar_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = axi_pkg::OKAY;
    m_r_last_i   = 1'b0;
    cfg_valid_i  = 1'b0;
    cfg_win_i    = '0;
    cfg_sel_i    = remap_pkg::SEL_BASE;
    cfg_data_i   = '0;
  endtask

  // New payload only where the last edge did not leave a transfer waiting
  task automatic drive_random();
    if (!(s_aw_valid_i && !m_aw_ready_i)) begin
      s_aw_valid_i = 1'($urandom);
      s_aw_id_i    = axi_pkg::id_t'($urandom);
      s_aw_addr_i  = rand_addr();
      s_aw_len_i   = axi_pkg::len_t'($urandom);
    end
    if (!(s_ar_valid_i && !m_ar_ready_i)) begin
      s_ar_valid_i = 1'($urandom);
      s_ar_id_i    = axi_pkg::id_t'($urandom);
      s_ar_addr_i  = rand_addr();
      s_ar_len_i   = axi_pkg::len_t'($urandom);
    end
    if (!(s_w_valid_i && !m_w_ready_i)) begin
      s_w_valid_i = 1'($urandom);
      s_w_data_i  = $urandom;
      s_w_last_i  = 1'($urandom);
    end
    if (!(m_b_valid_i && !s_b_ready_i)) begin
      m_b_valid_i = 1'($urandom);
      m_b_id_i    = axi_pkg::id_t'($urandom);
      m_b_resp_i  = axi_pkg::resp_e'(2'($urandom));
    end
    if (!(m_r_valid_i && !s_r_ready_i)) begin
      m_r_valid_i = 1'($urandom);
      m_r_id_i    = axi_pkg::id_t'($urandom);
      m_r_data_i  = $urandom;
      m_r_resp_i  = axi_pkg::resp_e'(2'($urandom));
      m_r_last_i  = 1'($urandom);
    end
    m_aw_ready_i = 1'($urandom);
    m_ar_ready_i = 1'($urandom);
    m_w_ready_i  = 1'($urandom);
    s_b_ready_i  = 1'($urandom);
    s_r_ready_i  = 1'($urandom);
  endtask

  task automatic random_traffic(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      drive_random();
    end
  endtask

  // Let every open transfer finish, then go idle
  task automatic settle();
    @(negedge clk_i);
    m_aw_ready_i = 1'b1;
    m_ar_ready_i = 1'b1;
    m_w_ready_i  = 1'b1;
    s_b_ready_i  = 1'b1;
    s_r_ready_i  = 1'b1;
    @(negedge clk_i);
    s_aw_valid_i = 1'b0;
    s_ar_valid_i = 1'b0;
    s_w_valid_i  = 1'b0;
    m_b_valid_i  = 1'b0;
    m_r_valid_i  = 1'b0;
  endtask

  task automatic cfg_write(input remap_pkg::win_idx_t win, input remap_pkg::cfg_sel_e sel,
                           input axi_pkg::addr_t data);
    @(negedge clk_i);
    cfg_valid_i = 1'b1;
    cfg_win_i   = win;
    cfg_sel_i   = sel;
    cfg_data_i  = data;
    @(posedge clk_i);
    while (!cfg_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
  endtask

  task automatic program_windows();
    for (int k = 0; k < remap_pkg::NumWindows; k++) begin
      cfg_write(remap_pkg::win_idx_t'(k), remap_pkg::SEL_BASE, BaseCfg[k]);
      cfg_write(remap_pkg::win_idx_t'(k), remap_pkg::SEL_MASK, MaskCfg[k]);
      cfg_write(remap_pkg::win_idx_t'(k), remap_pkg::SEL_TARGET, TargetCfg[k]);
      cfg_write(remap_pkg::win_idx_t'(k), remap_pkg::SEL_ENABLE, 32'd1);
    end
  endtask

  // Address in window 2 held by the master side while window 2 is retargeted
  task automatic hold_address(input logic is_ar);
    axi_pkg::addr_t addr;
    addr = {16'h4000, 16'($urandom)};
    @(negedge clk_i);
    if (is_ar) begin
      s_ar_valid_i = 1'b1;
      s_ar_addr_i  = addr;
      m_ar_ready_i = 1'b0;
    end else begin
      s_aw_valid_i = 1'b1;
      s_aw_addr_i  = addr;
      m_aw_ready_i = 1'b0;
    end
    cfg_valid_i = 1'b1;
    cfg_win_i   = 2'd2;
    cfg_sel_i   = remap_pkg::SEL_TARGET;
    cfg_data_i  = axi_pkg::addr_t'($urandom);
    repeat (HoldCycles) begin
      @(posedge clk_i);
      check_bit(cfg_ready_o, 1'b0, "cfg_ready_o with address pending");
    end
    // Address and configuration write complete on the same edge
    @(negedge clk_i);
    m_ar_ready_i = 1'b1;
    m_aw_ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
    s_aw_valid_i = 1'b0;
    cfg_valid_i  = 1'b0;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
      stop_on_failure();
    end
  end

  // Shadow follows the handshake on this edge, outputs are checked once settled
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int k = 0; k < remap_pkg::NumWindows; k++) begin
        sh_base[k]   = '0;
        sh_mask[k]   = '0;
        sh_target[k] = '0;
        sh_en[k]     = 1'b0;
      end
    end else if (cfg_valid_i && cfg_ready_o) begin
      case (cfg_sel_i)
        remap_pkg::SEL_BASE:   sh_base[cfg_win_i] = cfg_data_i;
        remap_pkg::SEL_MASK:   sh_mask[cfg_win_i] = cfg_data_i;
        remap_pkg::SEL_TARGET: sh_target[cfg_win_i] = cfg_data_i;
        default:               sh_en[cfg_win_i] = cfg_data_i[0];
      endcase
    end
    #5;
    if (rst_n_i) begin
      check_outputs();
    end
  end

  initial begin
    void'($urandom(Seed));
    init_inputs();
    @(posedge rst_n_i);
    // No windows yet, everything passes through
    random_traffic(IdleCycles);
    settle();
    program_windows();
    random_traffic(MappedCycles);
    settle();
    // Window 0 off, its range falls to window 1 or passes through
    cfg_write(2'd0, remap_pkg::SEL_ENABLE, '0);
    random_traffic(DisabledCycles);
    settle();
    hold_address(1'b0);
    hold_address(1'b1);
    settle();
    @(posedge clk_i);
    // Last settled check lands before this
    #10;
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/axi_pkg.sv
hw/remap_pkg.sv
hw/remap_cfg_regs.sv
hw/remap_lookup.sv
hw/axi_modify_address.sv
hw/axi_remap_top.sv
testbench/tb_clk_gen.sv
testbench/tb_axi_remap.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI remapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f list.f --top-module tb_axi_remap \
  -Mdir obj_dir -o sim_axi_remap

# The simulator exits non-zero on a fatal error, the log decides the result
./obj_dir/sim_axi_remap > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi
